//--- source/armPkg.sv
package armPkg;

  // Data-processing view, register operand sits in imm8[3:0]
  typedef struct packed {
    logic [3:0] cond;
    logic [1:0] op;
    logic       immFlag;
    logic [3:0] opcode;
    logic       setFlags;
    logic [3:0] rn;
    logic [3:0] rd;
    logic [3:0] rot;
    logic [7:0] imm8;
  } dpFieldsT;

  // Load/store view
  typedef struct packed {
    logic [3:0]  cond;
    logic [1:0]  op;
    logic        notImm;
    logic        preIndex;
    logic        up;
    logic        byteFlag;
    logic        writeBack;
    logic        load;
    logic [3:0]  rn;
    logic [3:0]  rd;
    logic [11:0] imm12;
  } memFieldsT;

  // Branch view
  typedef struct packed {
    logic [3:0]  cond;
    logic [1:0]  op;
    logic [1:0]  fill;
    logic [23:0] imm24;
  } brFieldsT;

  // One instruction word, three decodings
  typedef union packed {
    dpFieldsT  dp;
    memFieldsT mem;
    brFieldsT  br;
  } instrT;

  // Data-processing opcodes
  localparam logic [3:0] OPC_AND = 4'b0000;
  localparam logic [3:0] OPC_EOR = 4'b0001;
  localparam logic [3:0] OPC_SUB = 4'b0010;
  localparam logic [3:0] OPC_ADD = 4'b0100;
  localparam logic [3:0] OPC_CMP = 4'b1010;
  localparam logic [3:0] OPC_ORR = 4'b1100;
  localparam logic [3:0] OPC_MOV = 4'b1101;

  // Instruction classes, bits 27:26
  localparam logic [1:0] OP_DP  = 2'b00;
  localparam logic [1:0] OP_MEM = 2'b01;
  localparam logic [1:0] OP_BR  = 2'b10;

  // Supported condition codes
  localparam logic [3:0] COND_EQ = 4'b0000;
  localparam logic [3:0] COND_NE = 4'b0001;
  localparam logic [3:0] COND_AL = 4'b1110;

  typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_ORR, ALU_EOR, ALU_PASSB} aluCtrlT;
  typedef enum logic [1:0] {IMM_DP, IMM_MEM, IMM_BR} immSrcT;
  typedef enum logic [1:0] {FWD_NONE, FWD_WB, FWD_MEM} fwdSelT;

  // First fetch address
  localparam logic [31:0] PC_RESET = 32'h0000_0000;

endpackage

//--- source/regFile.sv
module regFile (
  input  logic        clk,
  input  logic        regWrite,
  input  logic [3:0]  ra1,
  input  logic [3:0]  ra2,
  input  logic [3:0]  wa3,
  input  logic [31:0] wd3,
  input  logic [31:0] pcPlus8,
  output logic [31:0] rd1,
  output logic [31:0] rd2
);

  // r0 to r14, r15 comes from the fetch PC
  logic [31:0] regs [15];

  // Falling edge write, so decode sees writeback in the same cycle
  always_ff @(negedge clk) begin
    if (regWrite && (wa3 != 4'd15)) begin
      regs[wa3] <= wd3;
    end
  end

  // Reads of r15 return PC+8
  assign rd1 = (ra1 == 4'd15) ? pcPlus8 : regs[ra1];
  assign rd2 = (ra2 == 4'd15) ? pcPlus8 : regs[ra2];

endmodule

//--- source/immExtend.sv
module immExtend (
  input  armPkg::instrT  instrD,
  input  armPkg::immSrcT immSrc,
  output logic [31:0]    extImm
);
  import armPkg::*;

  logic [4:0]  rotAmt;
  logic [63:0] rotPair;

  // Rotate right by twice rot
  // Shifting two copies side by side wraps the low bits around
  assign rotAmt  = {instrD.dp.rot, 1'b0};
  assign rotPair = {24'b0, instrD.dp.imm8, 24'b0, instrD.dp.imm8} >> rotAmt;

  always_comb begin
    case (immSrc)
      IMM_DP:  extImm = rotPair[31:0];
      // Unsigned load/store offset
      IMM_MEM: extImm = {20'b0, instrD.mem.imm12};
      // Word offset, sign extended
      IMM_BR:  extImm = {{6{instrD.br.imm24[23]}}, instrD.br.imm24, 2'b00};
      default: extImm = 32'b0;
    endcase
  end

endmodule

//--- source/alu.sv
module alu (
  input  logic [31:0]     a,
  input  logic [31:0]     b,
  input  armPkg::aluCtrlT aluCtrl,
  output logic [31:0]     result,
  output logic [3:0]      flags
);
  import armPkg::*;

  logic        isSub;
  logic        arith;
  logic [31:0] bIn;
  logic [32:0] sum;
  logic        carry;
  logic        overflow;

  // Subtract as a + ~b + 1 through the same adder
  assign isSub = (aluCtrl == ALU_SUB);
  assign arith = (aluCtrl == ALU_ADD) || isSub;
  assign bIn   = isSub ? ~b : b;
  assign sum   = {1'b0, a} + {1'b0, bIn} + {32'b0, isSub};

  always_comb begin
    case (aluCtrl)
      ALU_ADD, ALU_SUB: result = sum[31:0];
      ALU_AND:   result = a & b;
      ALU_ORR:   result = a | b;
      ALU_EOR:   result = a ^ b;
      ALU_PASSB: result = b;
      default:   result = 32'b0;
    endcase
  end

  // On subtract the carry is the inverted borrow
  assign carry    = arith & sum[32];
  // Like-signed operands giving the other sign
  assign overflow = arith & (a[31] == bIn[31]) & (sum[31] != a[31]);

  // NZCV
  assign flags = {result[31], (result == 32'b0), carry, overflow};

endmodule

//--- source/byteLanes.sv
module byteLanes (
  input  logic        byteE,
  input  logic [31:0] writeDataE,
  input  logic [1:0]  addrLowE,
  output logic [31:0] writeDataReplE,
  output logic [3:0]  byteEnE,
  input  logic        byteW,
  input  logic [1:0]  addrLowW,
  input  logic [31:0] readDataRawW,
  output logic [31:0] readDataW
);

  // Store side
  // Byte data goes out on all four lanes, one enable picks the lane
  assign writeDataReplE = byteE ? {4{writeDataE[7:0]}} : writeDataE;
  assign byteEnE        = byteE ? (4'b0001 << addrLowE) : 4'b1111;

  // Load side
  // Pick the addressed byte and zero extend it
  assign readDataW = byteW ? {24'b0, readDataRawW[{addrLowW, 3'b000} +: 8]}
                           : readDataRawW;

endmodule

//--- source/controller.sv
module controller (
  input  logic            clk,
  input  logic            rstN,
  input  armPkg::instrT   instrD,
  input  logic [3:0]      aluFlagsE,
  input  logic            flushE,
  output armPkg::immSrcT  immSrcD,
  output logic [1:0]      regSrcD,
  output logic            aluSrcE,
  output armPkg::aluCtrlT aluCtrlE,
  output logic            branchTakenE,
  output logic            memToRegE,
  output logic            byteE,
  output logic            memWriteM,
  output logic            regWriteM,
  output logic            memToRegW,
  output logic            regWriteW,
  output logic            byteW
);
  import armPkg::*;

  logic       regWriteD, memWriteD, memToRegD, branchD, flagWriteD, aluSrcD, byteD;
  aluCtrlT    aluCtrlD;
  logic       regWriteE, memWriteE, branchE, flagWriteE;
  logic [3:0] condE;
  logic       condPassE;
  logic       memToRegM, byteM;
  // NZCV flag register
  logic [3:0] flagsQ;

  // ==================================================================
  // Decode
  // ==================================================================
  always_comb begin
    regWriteD  = 1'b0;
    memWriteD  = 1'b0;
    memToRegD  = 1'b0;
    branchD    = 1'b0;
    flagWriteD = 1'b0;
    aluSrcD    = 1'b1;
    byteD      = 1'b0;
    aluCtrlD   = ALU_ADD;
    immSrcD    = IMM_DP;
    // Bit 0 reads r15 on port 1, bit 1 reads rd on port 2
    regSrcD    = 2'b00;
    case (instrD.dp.op)
      OP_DP: begin
        aluSrcD    = instrD.dp.immFlag;
        regWriteD  = (instrD.dp.opcode != OPC_CMP);
        flagWriteD = instrD.dp.setFlags || (instrD.dp.opcode == OPC_CMP);
        case (instrD.dp.opcode)
          OPC_SUB, OPC_CMP: aluCtrlD = ALU_SUB;
          OPC_AND: aluCtrlD = ALU_AND;
          OPC_ORR: aluCtrlD = ALU_ORR;
          OPC_EOR: aluCtrlD = ALU_EOR;
          OPC_MOV: aluCtrlD = ALU_PASSB;
          default: aluCtrlD = ALU_ADD;
        endcase
      end
      OP_MEM: begin
        immSrcD   = IMM_MEM;
        regWriteD = instrD.mem.load;
        memToRegD = instrD.mem.load;
        memWriteD = !instrD.mem.load;
        byteD     = instrD.mem.byteFlag;
        // Stores need rd as the data operand
        regSrcD   = {!instrD.mem.load, 1'b0};
        aluCtrlD  = instrD.mem.up ? ALU_ADD : ALU_SUB;
      end
      OP_BR: begin
        // Target is PC+8 plus the offset
        immSrcD = IMM_BR;
        branchD = 1'b1;
        regSrcD = 2'b01;
      end
      default: ;
    endcase
  end

  // ==================================================================
  // Execute, a flush turns the entry into a bubble
  // ==================================================================
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      regWriteE  <= 1'b0;
      memWriteE  <= 1'b0;
      memToRegE  <= 1'b0;
      branchE    <= 1'b0;
      flagWriteE <= 1'b0;
      aluSrcE    <= 1'b0;
      byteE      <= 1'b0;
      aluCtrlE   <= ALU_ADD;
      condE      <= 4'b0;
    end else begin
      regWriteE  <= regWriteD & ~flushE;
      memWriteE  <= memWriteD & ~flushE;
      memToRegE  <= memToRegD & ~flushE;
      branchE    <= branchD & ~flushE;
      flagWriteE <= flagWriteD & ~flushE;
      aluSrcE    <= aluSrcD & ~flushE;
      byteE      <= byteD & ~flushE;
      aluCtrlE   <= flushE ? ALU_ADD : aluCtrlD;
      condE      <= flushE ? 4'b0 : instrD.dp.cond;
    end
  end

  // Only Z matters for EQ and NE
  always_comb begin
    case (condE)
      COND_EQ: condPassE = flagsQ[2];
      COND_NE: condPassE = !flagsQ[2];
      COND_AL: condPassE = 1'b1;
      default: condPassE = 1'b0;
    endcase
  end

  assign branchTakenE = branchE & condPassE;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      flagsQ <= 4'b0;
    end else if (flagWriteE && condPassE) begin
      flagsQ <= aluFlagsE;
    end
  end

  // ==================================================================
  // Memory and writeback
  // ==================================================================
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      regWriteM <= 1'b0;
      memWriteM <= 1'b0;
      memToRegM <= 1'b0;
      byteM     <= 1'b0;
      regWriteW <= 1'b0;
      memToRegW <= 1'b0;
      byteW     <= 1'b0;
    end else begin
      // Failed condition drops the side effects here
      regWriteM <= regWriteE & condPassE;
      memWriteM <= memWriteE & condPassE;
      memToRegM <= memToRegE;
      byteM     <= byteE;
      regWriteW <= regWriteM;
      memToRegW <= memToRegM;
      byteW     <= byteM;
    end
  end

endmodule

//--- source/hazardUnit.sv
module hazardUnit (
  input  logic [3:0]     ra1D,
  input  logic [3:0]     ra2D,
  input  logic [3:0]     ra1E,
  input  logic [3:0]     ra2E,
  input  logic [3:0]     wa3E,
  input  logic [3:0]     wa3M,
  input  logic [3:0]     wa3W,
  input  logic           regWriteM,
  input  logic           regWriteW,
  input  logic           memToRegE,
  input  logic           branchTakenE,
  output armPkg::fwdSelT forwardAE,
  output armPkg::fwdSelT forwardBE,
  output logic           stallF,
  output logic           stallD,
  output logic           flushD,
  output logic           flushE
);
  import armPkg::*;

  logic loadUseD;

  // Newer result in memory wins over writeback
  always_comb begin
    if (regWriteM && (ra1E == wa3M)) forwardAE = FWD_MEM;
    else if (regWriteW && (ra1E == wa3W)) forwardAE = FWD_WB;
    else forwardAE = FWD_NONE;

    if (regWriteM && (ra2E == wa3M)) forwardBE = FWD_MEM;
    else if (regWriteW && (ra2E == wa3W)) forwardBE = FWD_WB;
    else forwardBE = FWD_NONE;
  end

  // Load in execute feeding the instruction in decode
  // Load data is ready only in writeback, so wait one cycle
  assign loadUseD = memToRegE && ((ra1D == wa3E) || (ra2D == wa3E));

  assign stallF = loadUseD;
  assign stallD = loadUseD;
  // Taken branch kills the two younger instructions
  assign flushD = branchTakenE;
  assign flushE = loadUseD || branchTakenE;

endmodule

//--- source/datapath.sv
module datapath (
  input  logic            clk,
  input  logic            rstN,
  input  logic [31:0]     instrF,
  input  logic [31:0]     readDataM,
  output logic [31:0]     pcF,
  output logic [31:0]     aluOutM,
  output logic [31:0]     writeDataM,
  output logic [3:0]      byteEnM,
  output armPkg::instrT   instrD,
  output logic [3:0]      aluFlagsE,
  input  armPkg::immSrcT  immSrcD,
  input  logic [1:0]      regSrcD,
  input  logic            aluSrcE,
  input  armPkg::aluCtrlT aluCtrlE,
  input  logic            branchTakenE,
  input  logic            byteE,
  input  logic            memToRegW,
  input  logic            regWriteW,
  input  logic            byteW,
  input  armPkg::fwdSelT  forwardAE,
  input  armPkg::fwdSelT  forwardBE,
  input  logic            stallF,
  input  logic            stallD,
  input  logic            flushD,
  input  logic            flushE,
  output logic [3:0]      ra1D,
  output logic [3:0]      ra2D,
  output logic [3:0]      ra1E,
  output logic [3:0]      ra2E,
  output logic [3:0]      wa3E,
  output logic [3:0]      wa3M,
  output logic [3:0]      wa3W
);
  import armPkg::*;

  logic [31:0] pcPlus4F, pcNextF;
  logic [31:0] rd1D, rd2D, extImmD;
  logic [31:0] rd1E, rd2E, extImmE, srcAE, srcBE, writeDataE;
  logic [31:0] aluResultE, writeDataReplE;
  logic [3:0]  byteEnE;
  logic [31:0] aluOutW, readDataRawW, readDataW, resultW;

  // Bypass select for one execute operand
  function automatic logic [31:0] fwdMux(fwdSelT sel, logic [31:0] regVal,
                                         logic [31:0] wbVal, logic [31:0] memVal);
    case (sel)
      FWD_WB:  return wbVal;
      FWD_MEM: return memVal;
      default: return regVal;
    endcase
  endfunction

  // ====================================================================
  // Fetch
  // ====================================================================
  assign pcPlus4F = pcF + 32'd4;
  // Branch target comes straight from the ALU
  assign pcNextF  = branchTakenE ? aluResultE : pcPlus4F;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) pcF <= PC_RESET;
    else if (!stallF) pcF <= pcNextF;
  end

  // ====================================================================
  // Decode
  // ====================================================================
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) instrD <= '0;
    else if (!stallD) instrD <= flushD ? '0 : instrF;
  end

  // r15 for branches, rd for store data
  assign ra1D = regSrcD[0] ? 4'd15 : instrD.dp.rn;
  assign ra2D = regSrcD[1] ? instrD.dp.rd : instrD.dp.imm8[3:0];

  // Fetch PC runs one word ahead of decode, so PC+4 here is PC+8 there
  regFile rf (
    .clk(clk), .regWrite(regWriteW), .ra1(ra1D), .ra2(ra2D), .wa3(wa3W),
    .wd3(resultW), .pcPlus8(pcPlus4F), .rd1(rd1D), .rd2(rd2D)
  );

  immExtend ext (.instrD(instrD), .immSrc(immSrcD), .extImm(extImmD));

  // ====================================================================
  // Execute
  // ====================================================================
  always_ff @(posedge clk) begin
    rd1E    <= rd1D;
    rd2E    <= rd2D;
    extImmE <= extImmD;
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      ra1E <= 4'd0;
      ra2E <= 4'd0;
      wa3E <= 4'd0;
    end else begin
      ra1E <= flushE ? 4'd0 : ra1D;
      ra2E <= flushE ? 4'd0 : ra2D;
      wa3E <= flushE ? 4'd0 : instrD.dp.rd;
    end
  end

  assign srcAE      = fwdMux(forwardAE, rd1E, resultW, aluOutM);
  assign writeDataE = fwdMux(forwardBE, rd2E, resultW, aluOutM);
  assign srcBE      = aluSrcE ? extImmE : writeDataE;

  alu aluE (
    .a(srcAE), .b(srcBE), .aluCtrl(aluCtrlE), .result(aluResultE), .flags(aluFlagsE)
  );

  // Store lanes are set up in execute, load lanes in writeback
  byteLanes lanes (
    .byteE(byteE), .writeDataE(writeDataE), .addrLowE(aluResultE[1:0]),
    .writeDataReplE(writeDataReplE), .byteEnE(byteEnE),
    .byteW(byteW), .addrLowW(aluOutW[1:0]), .readDataRawW(readDataRawW),
    .readDataW(readDataW)
  );

  // ====================================================================
  // Memory and writeback
  // ====================================================================
  always_ff @(posedge clk) begin
    aluOutM      <= aluResultE;
    writeDataM   <= writeDataReplE;
    byteEnM      <= byteEnE;
    aluOutW      <= aluOutM;
    readDataRawW <= readDataM;
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      wa3M <= 4'd0;
      wa3W <= 4'd0;
    end else begin
      wa3M <= wa3E;
      wa3W <= wa3M;
    end
  end

  assign resultW = memToRegW ? readDataW : aluOutW;

endmodule

//--- source/armCore.sv
module armCore (
  input  logic        clk,
  input  logic        rstN,
  output logic [31:0] pcF,
  input  logic [31:0] instrF,
  output logic [31:0] aluOutM,
  output logic [31:0] writeDataM,
  output logic        memWriteM,
  output logic [3:0]  byteEnM,
  input  logic [31:0] readDataM
);
  import armPkg::*;

  // Controller and datapath
  instrT      instrD;
  logic [3:0] aluFlagsE;
  immSrcT     immSrcD;
  logic [1:0] regSrcD;
  logic       aluSrcE;
  aluCtrlT    aluCtrlE;
  logic       branchTakenE;
  logic       memToRegE;
  logic       byteE;
  logic       regWriteM;
  logic       memToRegW;
  logic       regWriteW;
  logic       byteW;

  // Hazard handling
  fwdSelT     forwardAE, forwardBE;
  logic       stallF, stallD, flushD, flushE;
  logic [3:0] ra1D, ra2D, ra1E, ra2E, wa3E, wa3M, wa3W;

  // All nets share port names, so connect by name
  controller ctrl (.*);

  hazardUnit hazard (.*);

  datapath dp (.*);

endmodule

//--- tb/tbArmCore.sv
module tbArmCore;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int MEM_WORDS     = 64;
  localparam int MAX_STORES    = 32;
  localparam int STORE_TIMEOUT = 100;
  localparam int QUIET_CYCLES  = 20;
  localparam int RESET_CYCLES  = 10;

  logic        clk;
  logic        rstN;
  logic [31:0] pcF;
  logic [31:0] instrF;
  logic [31:0] aluOutM;
  logic [31:0] writeDataM;
  logic        memWriteM;
  logic [3:0]  byteEnM;
  logic [31:0] readDataM;

  // Separate word-indexed code and data memories
  logic [31:0] instrMem [MEM_WORDS];
  logic [31:0] dataMem  [MEM_WORDS];

  // Expected store trace from the golden file
  logic [31:0] expAddr   [MAX_STORES];
  logic [31:0] expData   [MAX_STORES];
  logic [3:0]  expByteEn [MAX_STORES];
  int          expCount     = 0;

  int          errorCount   = 0;
  int          timeoutCount = 0;
  int          storeCount   = 0;

  armCore DUT (
    .clk(clk), .rstN(rstN), .pcF(pcF), .instrF(instrF), .aluOutM(aluOutM),
    .writeDataM(writeDataM), .memWriteM(memWriteM), .byteEnM(byteEnM),
    .readDataM(readDataM)
  );

  // 40 ns period
  initial clk = 1'b0;
  always #20 clk = ~clk;

  // ======================================================================
  // Memory models
  // ======================================================================
  // Both memories answer in the same cycle
  assign instrF    = instrMem[pcF[7:2]];
  assign readDataM = dataMem[aluOutM[7:2]];

  // Store applied on the falling edge, where the strobe is stable
  always @(negedge clk) begin
    if (rstN && memWriteM) begin
      storeCount = storeCount + 1;
      for (int lane = 0; lane < 4; lane++) begin
        if (byteEnM[lane]) begin
          dataMem[aluOutM[7:2]][lane*8 +: 8] = writeDataM[lane*8 +: 8];
        end
      end
    end
  end

  task automatic checkEqual(input logic [31:0] actual, input logic [31:0] expected,
                            input string what);
    if (actual !== expected) begin
      errorCount++;
      $display("error at %0d ns: %s is %h, expected %h", $time, what, actual, expected);
    end
  endtask

  // Tag 1 program word, tag 2 data word, tag 3 expected store
  task automatic loadGolden(output bit loaded);
    int                 fd;
    int                 fields;
    logic [8*160-1:0]   lineText;
    logic [31:0]        tag;
    logic [31:0]        addr;
    logic [31:0]        data;
    logic [31:0]        byteEn;
    loaded = 1'b0;
    fd = $fopen("tb/armGolden.hex", "r");
    if (fd == 0) begin
      errorCount++;
      $display("Could not open tb/armGolden.hex, nothing to run");
      return;
    end
    // Comment and blank lines do not give four fields
    while ($fgets(lineText, fd) != 0) begin
      fields = $sscanf(lineText, "%h %h %h %h", tag, addr, data, byteEn);
      if (fields == 4) begin
        case (tag)
          32'h1: instrMem[addr[7:2]] = data;
          32'h2: dataMem[addr[7:2]] = data;
          32'h3: begin
            if (expCount < MAX_STORES) begin
              expAddr[expCount]   = addr;
              expData[expCount]   = data;
              expByteEn[expCount] = byteEn[3:0];
              expCount++;
            end else begin
              errorCount++;
              $display("Golden file holds more stores than the table can take");
            end
          end
          default: begin
            errorCount++;
            $display("Golden file has a record with unknown tag %0h", tag);
          end
        endcase
      end
    end
    $fclose(fd);
    loaded = 1'b1;
  endtask

  // Waits a bounded number of cycles for the next store strobe
  task automatic waitForStore(input int index, output bit seen);
    int cycles;
    seen   = 1'b0;
    cycles = 0;
    while (!seen && cycles < STORE_TIMEOUT) begin
      @(negedge clk);
      cycles++;
      seen = (memWriteM === 1'b1);
    end
    if (!seen) begin
      timeoutCount++;
      $display("No store %0d appeared within %0d cycles", index, STORE_TIMEOUT);
    end
  endtask

  // ======================================================================
  // Main sequence
  // ======================================================================
  initial begin : mainFlow
    bit loaded;
    bit seen;
    rstN = 1'b0;
    // Unused code words are MOV r14 with the word index
    // Unused data words carry their own address
    for (int i = 0; i < MEM_WORDS; i++) begin
      instrMem[i] = 32'hE3A0_E000 | i;
      dataMem[i]  = 32'hD0D0_0000 | (i << 2);
    end
    loadGolden(loaded);
    repeat (RESET_CYCLES) @(negedge clk);
    // Core parked at the first fetch address with no store strobe
    checkEqual(pcF, 32'h0000_0000, "pcF during reset");
    checkEqual({31'b0, memWriteM}, 32'b0, "memWriteM during reset");
    rstN = 1'b1;

    if (loaded) begin
      for (int k = 0; k < expCount && timeoutCount == 0; k++) begin
        waitForStore(k, seen);
        if (seen) begin
          checkEqual(aluOutM, expAddr[k], $sformatf("store %0d address", k));
          checkEqual(writeDataM, expData[k], $sformatf("store %0d data", k));
          checkEqual({28'b0, byteEnM}, {28'b0, expByteEn[k]},
                     $sformatf("store %0d byte enable", k));
        end
      end
      // Core spins on its last branch and must not store again
      if (timeoutCount == 0) begin
        repeat (QUIET_CYCLES) @(negedge clk);
        @(posedge clk);
        checkEqual(storeCount, expCount, "store count");
      end
    end

    $display("Stores seen %0d of %0d expected, errors %0d, timeouts %0d",
             storeCount, expCount, errorCount, timeoutCount);
    if (errorCount == 0 && timeoutCount == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

//--- flist.f
source/armPkg.sv
source/regFile.sv
source/immExtend.sv
source/alu.sv
source/byteLanes.sv
source/controller.sv
source/hazardUnit.sv
source/datapath.sv
source/armCore.sv
tb/tbArmCore.sv

//--- Bender.yml
package:
  name: arm_core

sources:
  - source/armPkg.sv
  - source/regFile.sv
  - source/immExtend.sv
  - source/alu.sv
  - source/byteLanes.sv
  - source/controller.sv
  - source/hazardUnit.sv
  - source/datapath.sv
  - source/armCore.sv
  - target: test
    files:
      - tb/tbArmCore.sv

//--- tb/armGolden.hex
// Columns: tag address word byteEnable, all hex
// Tag 1 program word at address, tag 2 initial data word, tag 3 expected store
1 00000000 E3A06080 0  // MOV r6, #0x80
1 00000004 E3A01005 0  // MOV r1, #5
1 00000008 E3A024FF 0  // MOV r2, #0xFF000000
1 0000000C E0813002 0  // ADD r3, r1, r2
1 00000010 E5863000 0  // STR r3, [r6]
1 00000014 E2434001 0  // SUB r4, r3, #1
1 00000018 E0245001 0  // EOR r5, r4, r1
1 0000001C E3857E3F 0  // ORR r7, r5, #0x3F0
1 00000020 E2077EFF 0  // AND r7, r7, #0xFF0
1 00000024 E5865004 0  // STR r5, [r6, #4]
1 00000028 E5867008 0  // STR r7, [r6, #8]
1 0000002C E5968020 0  // LDR r8, [r6, #0x20]
1 00000030 E0889001 0  // ADD r9, r8, r1
1 00000034 E586900C 0  // STR r9, [r6, #0xC]
1 00000038 E5C63011 0  // STRB r3, [r6, #0x11]
1 0000003C E5D6A022 0  // LDRB r10, [r6, #0x22]
1 00000040 E586A014 0  // STR r10, [r6, #0x14]
1 00000044 E3510005 0  // CMP r1, #5
1 00000048 1A000001 0  // BNE 0x54
1 0000004C E5861018 0  // STR r1, [r6, #0x18]
1 00000050 0A000001 0  // BEQ 0x5C
1 00000054 E586201C 0  // STR r2, [r6, #0x1C]
1 00000058 E586201C 0  // STR r2, [r6, #0x1C]
1 0000005C E3510004 0  // CMP r1, #4
1 00000060 0AFFFFFB 0  // BEQ 0x54
1 00000064 EA000001 0  // B 0x70
1 00000068 E586201C 0  // STR r2, [r6, #0x1C]
1 0000006C E586201C 0  // STR r2, [r6, #0x1C]
1 00000070 E586401C 0  // STR r4, [r6, #0x1C]
1 00000074 EAFFFFFE 0  // B 0x74
2 000000A0 12345678 0
3 00000080 FF000005 F
3 00000084 FF000001 F
3 00000088 000003F0 F
3 0000008C 1234567D F
3 00000091 05050505 2
3 00000094 00000034 F
3 00000098 00000005 F
3 0000009C FF000004 F
